// ==== Makefile ====
# Verilator build and run of the fetch queue testbench.

VERILATOR ?= verilator
FILELIST  ?= verilog.f
TB_TOP    ?= tb_fetch_queue
RTL_TOP   ?= fetch_queue_top
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= tests failed
VFLAGS    ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verif/tb_fetch_queue.sv ====
module tb_fetch_queue;

    timeunit 1ns;
    timeprecision 100ps;

    // the directed tests and the burst take a few hundred cycles.
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int WAIT_LIMIT     = 100;

    logic                                clk;
    logic                                rst_n;
    logic                                flush;
    logic                                in_valid;
    logic                                in_pair;
    logic [fetch_pkg::XLEN-1:0]          in_pc;
    logic [2*fetch_pkg::XLEN-1:0]        in_insn;
    logic [fetch_pkg::XLEN-1:0]          in_npc;
    logic [fetch_pkg::PLV_W-1:0]         in_plv;
    logic [fetch_pkg::EXCP_W-1:0]        in_excp_arg;
    logic                                fb_full;
    logic [fetch_pkg::LANES-1:0]         out_valid;
    logic [fetch_pkg::XLEN-1:0]          out_pc0;
    logic [fetch_pkg::XLEN-1:0]          out_pc1;
    logic [fetch_pkg::XLEN-1:0]          out_insn0;
    logic [fetch_pkg::XLEN-1:0]          out_insn1;
    logic [fetch_pkg::XLEN-1:0]          out_npc0;
    logic [fetch_pkg::XLEN-1:0]          out_npc1;
    fetch_pkg::insn_class_e              out_class0;
    fetch_pkg::insn_class_e              out_class1;
    logic [fetch_pkg::EXCP_W-1:0]        out_excp_arg0;
    logic [fetch_pkg::EXCP_W-1:0]        out_excp_arg1;
    logic                                out_ready;

    int          errors = 0;
    int          checks = 0;
    int          taken  = 0;    // instructions accepted by the decoder.
    int          cycles = 0;
    int unsigned seed_draw;
    logic [31:0] next_pc;

    // reference model: queue contents and the two lane registers.
    fetch_pkg::fetch_entry_t model_q [$];
    fetch_pkg::fetch_entry_t lane_e [2];
    logic [1:0]              lane_v = 2'b00;

    fetch_queue_top u_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush         (flush),
        .in_valid      (in_valid),
        .in_pair       (in_pair),
        .in_pc         (in_pc),
        .in_insn       (in_insn),
        .in_npc        (in_npc),
        .in_plv        (in_plv),
        .in_excp_arg   (in_excp_arg),
        .fb_full       (fb_full),
        .out_valid     (out_valid),
        .out_pc0       (out_pc0),
        .out_pc1       (out_pc1),
        .out_insn0     (out_insn0),
        .out_insn1     (out_insn1),
        .out_npc0      (out_npc0),
        .out_npc1      (out_npc1),
        .out_class0    (out_class0),
        .out_class1    (out_class1),
        .out_excp_arg0 (out_excp_arg0),
        .out_excp_arg1 (out_excp_arg1),
        .out_ready     (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("tests failed");
            $finish;
        end
    end

    // ====================
    // checker and model
    // ====================
    task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    // opcode map: branches from the minimum up, a few singles, rest alu.
    function automatic fetch_pkg::insn_class_e expect_class(input logic [31:0] insn);
        logic [fetch_pkg::OPC_W-1:0] opc;
        opc = insn[fetch_pkg::OPC_LSB +: fetch_pkg::OPC_W];
        if (opc >= fetch_pkg::OPC_BRANCH_MIN) begin
            return fetch_pkg::CLS_BRANCH;
        end
        case (opc)
            fetch_pkg::OPC_LOAD:   return fetch_pkg::CLS_LOAD;
            fetch_pkg::OPC_STORE:  return fetch_pkg::CLS_STORE;
            fetch_pkg::OPC_SYSTEM: return fetch_pkg::CLS_SYSTEM;
            default:               return fetch_pkg::CLS_ALU;
        endcase
    endfunction

    function automatic logic [31:0] make_insn(input logic [5:0] opc, input logic [25:0] low);
        return {opc, low};
    endfunction

    task automatic check_slot(input string tag, input fetch_pkg::fetch_entry_t e,
                              input logic [31:0] pc, input logic [31:0] insn,
                              input logic [31:0] npc, input fetch_pkg::insn_class_e cls,
                              input logic [15:0] excp);
        check_eq({"out_pc", tag}, pc, e.pc);
        check_eq({"out_insn", tag}, insn, e.insn);
        check_eq({"out_npc", tag}, npc, e.npc);
        check_eq({"out_excp_arg", tag}, excp, e.excp_arg);
        check_eq({"out_class", tag}, cls, expect_class(e.insn));
    endtask

    // compares the outputs, then steps the model across the coming edge.
    task automatic model_step();
        logic                    kill;
        logic                    full;
        logic [1:0]              exp_valid;
        fetch_pkg::fetch_entry_t e;
        kill = lane_v[0] && (lane_e[0].excp_arg != '0
               || expect_class(lane_e[0].insn) == fetch_pkg::CLS_SYSTEM);
        exp_valid = {lane_v[1] && !kill, lane_v[0]};
        full = model_q.size() > fetch_pkg::FB_DEPTH - 2;    // fewer than two free.
        check_eq("out_valid", out_valid, exp_valid);
        check_eq("fb_full", fb_full, full);
        if (exp_valid[0]) begin
            check_slot("0", lane_e[0], out_pc0, out_insn0, out_npc0, out_class0, out_excp_arg0);
        end
        if (exp_valid[1]) begin
            check_slot("1", lane_e[1], out_pc1, out_insn1, out_npc1, out_class1, out_excp_arg1);
        end
        if (out_ready && out_valid != 2'b00) begin
            taken += $countones(out_valid);
        end
        if (flush) begin
            model_q.delete();
            lane_v = 2'b00;
        end else begin
            if (lane_v == 2'b00 || out_ready) begin
                for (int i = 0; i < 2; i++) begin
                    lane_v[i] = model_q.size() != 0;
                    if (lane_v[i]) begin
                        lane_e[i] = model_q.pop_front();
                    end
                end
            end
            if (in_valid && !full) begin
                e.pc       = in_pc;
                e.insn     = in_insn[31:0];
                e.npc      = in_npc;
                e.plv      = in_plv;
                e.excp_arg = in_excp_arg;
                model_q.push_back(e);
                if (in_pair) begin
                    e.pc       = in_pc + 32'd4;
                    e.insn     = in_insn[63:32];
                    e.excp_arg = '0;
                    model_q.push_back(e);
                end
            end
        end
    endtask

    always begin
        @(negedge clk);
        #1;    // inputs settled, outputs stable.
        if (rst_n) begin
            model_step();
        end
    end

    // ====================
    // drivers
    // ====================
    // starts and ends right after a falling edge.
    task automatic push_insn(input logic pair, input logic [31:0] pc, input logic [63:0] insn,
                             input logic [31:0] npc, input logic [15:0] excp);
        int waited;
        in_valid    = 1'b1;
        in_pair     = pair;
        in_pc       = pc;
        in_insn     = insn;
        in_npc      = npc;
        in_plv      = pc[3:2];
        in_excp_arg = excp;
        waited      = 0;
        while (fb_full && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (fb_full) begin
            errors++;
            $display("push of pc 0x%08h was never accepted, the queue stayed full", pc);
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    // idle once out_valid stays low for two cycles with out_ready high.
    task automatic wait_idle();
        int waited;
        int quiet;
        waited = 0;
        quiet  = 0;
        while (quiet < 2 && waited < WAIT_LIMIT) begin
            quiet = (out_valid == 2'b00) ? quiet + 1 : 0;
            @(negedge clk);
            waited++;
        end
        if (quiet < 2) begin
            errors++;
            $display("queue did not drain within %0d cycles", WAIT_LIMIT);
        end
    endtask

    // ====================
    // tests
    // ====================
    task automatic single_case(input logic [15:0] excp);
        logic [31:0] pc;
        pc = next_pc;
        push_insn(1'b0, pc, {32'h0, make_insn(6'h04, pc[27:2])}, pc + 32'h100, excp);
        check_eq("out_valid", out_valid, 2'b00);    // still in the queue.
        @(negedge clk);
        check_eq("out_valid", out_valid, 2'b01);
        check_eq("out_pc0", out_pc0, pc);
        check_eq("out_npc0", out_npc0, pc + 32'h100);
        check_eq("out_excp_arg0", out_excp_arg0, excp);
        next_pc += 8;
    endtask

    task automatic pair_case(input logic [15:0] excp, input logic [5:0] opc0,
                             input logic [1:0] exp_valid);
        logic [31:0] pc;
        pc = next_pc;
        push_insn(1'b1, pc, {make_insn(6'h05, pc[25:0]), make_insn(opc0, pc[27:2])},
                  pc + 32'h200, excp);
        @(negedge clk);
        check_eq("out_valid", out_valid, exp_valid);
        if (exp_valid[1]) begin
            check_eq("out_pc1", out_pc1, pc + 32'd4);
            check_eq("out_npc1", out_npc1, pc + 32'h200);
            check_eq("out_excp_arg1", out_excp_arg1, 16'h0);
        end
        next_pc += 8;
    endtask

    task automatic back_pressure();
        int          start;
        logic [31:0] first_pc;
        start     = taken;
        first_pc  = next_pc;
        out_ready = 1'b0;
        for (int k = 0; k < 9; k++) begin
            push_insn(1'b1, next_pc, {$urandom, make_insn(6'h02, 26'($urandom))},
                      next_pc + 32'h40, 16'h0);
            next_pc += 8;
        end
        check_eq("fb_full", fb_full, 1'b1);
        repeat (3) @(negedge clk);
        check_eq("out_valid", out_valid, 2'b11);
        check_eq("out_pc0", out_pc0, first_pc);    // oldest pair still held.
        out_ready = 1'b1;
        wait_idle();
        check_eq("drained count", taken - start, 18);
    endtask

    task automatic class_case(input logic [5:0] opc, input fetch_pkg::insn_class_e cls);
        push_insn(1'b0, next_pc, {32'h0, make_insn(opc, 26'h0123)}, next_pc + 32'd4, 16'h0);
        @(negedge clk);
        check_eq("out_valid", out_valid, 2'b01);
        check_eq("out_class0", out_class0, cls);
        next_pc += 8;
    endtask

    task automatic flush_case();
        out_ready = 1'b0;
        repeat (9) begin
            push_insn(1'b1, next_pc, {$urandom, $urandom}, next_pc + 32'h80, 16'h0);
            next_pc += 8;
        end
        check_eq("fb_full", fb_full, 1'b1);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        check_eq("out_valid", out_valid, 2'b00);
        check_eq("fb_full", fb_full, 1'b0);
        out_ready = 1'b1;
        single_case(16'h0);
        wait_idle();
    endtask

    task automatic random_burst(input int n);
        logic [31:0] r;
        logic [15:0] excp;
        for (int k = 0; k < n; k++) begin
            r         = $urandom;
            out_ready = (r[2:0] != 3'b000) || fb_full;    // never stall a full queue.
            excp      = (r[4:3] == 2'b00) ? (r[31:16] | 16'h1) : 16'h0;
            push_insn(r[5], next_pc, {$urandom, $urandom}, next_pc + 32'h40, excp);
            next_pc += 8;
        end
        out_ready = 1'b1;
        wait_idle();
    endtask

    initial begin
        seed_draw   = $urandom(32'h9727fd32);
        rst_n       = 1'b0;
        flush       = 1'b0;
        in_valid    = 1'b0;
        in_pair     = 1'b0;
        in_pc       = '0;
        in_insn     = '0;
        in_npc      = '0;
        in_plv      = '0;
        in_excp_arg = '0;
        out_ready   = 1'b1;
        next_pc     = 32'h0000_1000;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        check_eq("out_valid", out_valid, 2'b00);
        check_eq("fb_full", fb_full, 1'b0);
        single_case(16'h0);
        single_case(16'h0042);
        single_case(16'h0);
        wait_idle();

        repeat (4) pair_case(16'h0, 6'h02, 2'b11);
        wait_idle();

        back_pressure();

        class_case(6'h02, fetch_pkg::CLS_ALU);
        class_case(fetch_pkg::OPC_BRANCH_MIN + 6'd3, fetch_pkg::CLS_BRANCH);
        class_case(fetch_pkg::OPC_LOAD, fetch_pkg::CLS_LOAD);
        class_case(fetch_pkg::OPC_STORE, fetch_pkg::CLS_STORE);
        class_case(fetch_pkg::OPC_SYSTEM, fetch_pkg::CLS_SYSTEM);
        wait_idle();

        pair_case(16'h0bad, 6'h02, 2'b01);
        wait_idle();
        pair_case(16'h0, fetch_pkg::OPC_SYSTEM, 2'b01);
        wait_idle();

        flush_case();
        random_burst(40);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
verilog/fetch_pkg.sv
verilog/fetch_slot_if.sv
verilog/fetch_buffer.sv
verilog/predecode_lane.sv
verilog/dispatch_pair.sv
verilog/fetch_queue_top.sv
verif/tb_fetch_queue.sv

// ==== verilog/dispatch_pair.sv ====
module dispatch_pair (
    input  logic                             clk,
    input  logic                             rst_n,
    fetch_slot_if.sink                       lanes [fetch_pkg::LANES],
    input  logic                             out_ready,
    output logic                             advance,
    output logic [fetch_pkg::LANES-1:0]      out_valid,
    output logic [fetch_pkg::XLEN-1:0]       out_pc0,
    output logic [fetch_pkg::XLEN-1:0]       out_pc1,
    output logic [fetch_pkg::XLEN-1:0]       out_insn0,
    output logic [fetch_pkg::XLEN-1:0]       out_insn1,
    output logic [fetch_pkg::XLEN-1:0]       out_npc0,
    output logic [fetch_pkg::XLEN-1:0]       out_npc1,
    output fetch_pkg::insn_class_e           out_class0,
    output fetch_pkg::insn_class_e           out_class1,
    output logic [fetch_pkg::EXCP_W-1:0]     out_excp_arg0,
    output logic [fetch_pkg::EXCP_W-1:0]     out_excp_arg1
);

    logic kill;
    logic stage_busy;

    // an exception or syscall ends its pair.
    assign kill = lanes[0].valid
               && (lanes[0].excp || lanes[0].cls == fetch_pkg::CLS_SYSTEM);

    assign out_valid = {lanes[1].valid && !kill, lanes[0].valid};

    assign stage_busy = lanes[0].valid || lanes[1].valid;
    assign advance    = !stage_busy || out_ready;    // killed slot drops here.

    // ====================
    // payload
    // ====================
    assign out_pc0       = lanes[0].entry.pc;
    assign out_insn0     = lanes[0].entry.insn;
    assign out_npc0      = lanes[0].entry.npc;
    assign out_class0    = lanes[0].cls;
    assign out_excp_arg0 = lanes[0].entry.excp_arg;

    assign out_pc1       = lanes[1].entry.pc;
    assign out_insn1     = lanes[1].entry.insn;
    assign out_npc1      = lanes[1].entry.npc;
    assign out_class1    = lanes[1].cls;
    assign out_excp_arg1 = lanes[1].entry.excp_arg;

    // queue offers in order, so lane 1 never runs alone.
    a_pair_order: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid[1] |-> out_valid[0]
    );

endmodule

// ==== verilog/fetch_buffer.sv ====
module fetch_buffer (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             flush,
    input  logic                             in_valid,
    input  logic                             in_pair,
    input  logic [fetch_pkg::XLEN-1:0]       in_pc,
    input  logic [2*fetch_pkg::XLEN-1:0]     in_insn,
    input  logic [fetch_pkg::XLEN-1:0]       in_npc,
    input  logic [fetch_pkg::PLV_W-1:0]      in_plv,
    input  logic [fetch_pkg::EXCP_W-1:0]     in_excp_arg,
    input  logic                             advance,
    output logic                             fb_full,
    fetch_slot_if.src                        head [fetch_pkg::LANES]
);

    fetch_pkg::fetch_entry_t mem     [fetch_pkg::FB_DEPTH];    // index 0 is oldest.
    fetch_pkg::fetch_entry_t mem_nxt [fetch_pkg::FB_DEPTH];
    fetch_pkg::fetch_entry_t new0;
    fetch_pkg::fetch_entry_t new1;

    fetch_pkg::fb_cnt_t count;
    fetch_pkg::fb_cnt_t keep;
    fetch_pkg::fb_cnt_t pop_n;
    fetch_pkg::fb_cnt_t push_n;
    logic               push;

    // ====================
    // fill side
    // ====================
    assign fb_full = count > fetch_pkg::fb_cnt_t'(fetch_pkg::FB_DEPTH - 2);
    assign push    = in_valid && !fb_full;

    assign new0 = '{
        pc:       in_pc,
        insn:     in_insn[fetch_pkg::XLEN-1:0],
        npc:      in_npc,
        plv:      in_plv,
        excp_arg: in_excp_arg
    };

    // younger word of a pair, never carries the exception.
    assign new1 = '{
        pc:       in_pc + fetch_pkg::XLEN'(4),
        insn:     in_insn[2*fetch_pkg::XLEN-1:fetch_pkg::XLEN],
        npc:      in_npc,
        plv:      in_plv,
        excp_arg: '0
    };

    always_comb begin
        if (!push) begin
            push_n = '0;
        end else if (in_pair) begin
            push_n = fetch_pkg::fb_cnt_t'(2);
        end else begin
            push_n = fetch_pkg::fb_cnt_t'(1);
        end
    end

    // ====================
    // drain side
    // ====================
    always_comb begin
        if (!advance) begin
            pop_n = '0;
        end else if (count >= fetch_pkg::fb_cnt_t'(fetch_pkg::LANES)) begin
            pop_n = fetch_pkg::fb_cnt_t'(fetch_pkg::LANES);
        end else begin
            pop_n = count;    // offer only what is there.
        end
    end

    assign keep = count - pop_n;

    for (genvar g = 0; g < fetch_pkg::LANES; g++) begin : g_head
        assign head[g].valid = count > fetch_pkg::fb_cnt_t'(g);
        assign head[g].entry = mem[g];
    end

    // shift down by pop_n, then append behind the survivors.
    always_comb begin
        fetch_pkg::fb_cnt_t idx;
        fetch_pkg::fb_cnt_t src;
        for (int i = 0; i < fetch_pkg::FB_DEPTH; i++) begin
            idx = fetch_pkg::fb_cnt_t'(i);
            src = idx + pop_n;
            if (idx < keep) begin
                mem_nxt[i] = mem[src[fetch_pkg::FB_IDX_W-1:0]];
            end else if (idx == keep) begin
                mem_nxt[i] = new0;
            end else if (idx == keep + 1'b1) begin
                mem_nxt[i] = new1;
            end else begin
                mem_nxt[i] = mem[i];    // beyond count, don't care.
            end
        end
    end

    always_ff @(posedge clk) begin
        mem <= mem_nxt;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (flush) begin
            count <= '0;
        end else begin
            count <= keep + push_n;
        end
    end

    a_count_bound: assert property (
        @(posedge clk) disable iff (!rst_n)
        count <= fetch_pkg::fb_cnt_t'(fetch_pkg::FB_DEPTH)
    );

    // a held push while full must not grow the queue.
    a_no_push_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        (in_valid && fb_full) |=> count <= $past(count)
    );

endmodule

// ==== verilog/fetch_pkg.sv ====
package fetch_pkg;

    // ====================
    // queue geometry
    // ====================
    localparam int FB_DEPTH = 16;
    localparam int FB_PTR_W = 5;    // counts 0..FB_DEPTH.
    localparam int FB_IDX_W = 4;    // addresses one entry.
    localparam int LANES    = 2;

    localparam int XLEN     = 32;
    localparam int EXCP_W   = 16;
    localparam int PLV_W    = 2;

    typedef logic [FB_PTR_W-1:0] fb_cnt_t;

    // ====================
    // opcode field map
    // ====================
    localparam int OPC_LSB = 26;
    localparam int OPC_W   = 6;

    localparam logic [OPC_W-1:0] OPC_BRANCH_MIN = 6'h10;    // 0x10 and up are branches.
    localparam logic [OPC_W-1:0] OPC_LOAD       = 6'h0a;
    localparam logic [OPC_W-1:0] OPC_STORE      = 6'h0b;
    localparam logic [OPC_W-1:0] OPC_SYSTEM     = 6'h01;

    typedef enum logic [2:0] {
        CLS_ALU,
        CLS_BRANCH,
        CLS_LOAD,
        CLS_STORE,
        CLS_SYSTEM
    } insn_class_e;

    // one queued instruction, 114 bits.
    typedef struct packed {
        logic [XLEN-1:0]   pc;
        logic [XLEN-1:0]   insn;
        logic [XLEN-1:0]   npc;
        logic [PLV_W-1:0]  plv;
        logic [EXCP_W-1:0] excp_arg;
    } fetch_entry_t;

endpackage

// ==== verilog/fetch_queue_top.sv ====
module fetch_queue_top (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             flush,
    input  logic                             in_valid,
    input  logic                             in_pair,
    input  logic [fetch_pkg::XLEN-1:0]       in_pc,
    input  logic [2*fetch_pkg::XLEN-1:0]     in_insn,     // low word older.
    input  logic [fetch_pkg::XLEN-1:0]       in_npc,
    input  logic [fetch_pkg::PLV_W-1:0]      in_plv,
    input  logic [fetch_pkg::EXCP_W-1:0]     in_excp_arg,
    output logic                             fb_full,
    output logic [fetch_pkg::LANES-1:0]      out_valid,
    output logic [fetch_pkg::XLEN-1:0]       out_pc0,
    output logic [fetch_pkg::XLEN-1:0]       out_pc1,
    output logic [fetch_pkg::XLEN-1:0]       out_insn0,
    output logic [fetch_pkg::XLEN-1:0]       out_insn1,
    output logic [fetch_pkg::XLEN-1:0]       out_npc0,
    output logic [fetch_pkg::XLEN-1:0]       out_npc1,
    output fetch_pkg::insn_class_e           out_class0,
    output fetch_pkg::insn_class_e           out_class1,
    output logic [fetch_pkg::EXCP_W-1:0]     out_excp_arg0,
    output logic [fetch_pkg::EXCP_W-1:0]     out_excp_arg1,
    input  logic                             out_ready
);

    logic advance;

    fetch_slot_if q_slot [fetch_pkg::LANES] ();
    fetch_slot_if d_slot [fetch_pkg::LANES] ();

    fetch_buffer u_buffer (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .in_valid    (in_valid),
        .in_pair     (in_pair),
        .in_pc       (in_pc),
        .in_insn     (in_insn),
        .in_npc      (in_npc),
        .in_plv      (in_plv),
        .in_excp_arg (in_excp_arg),
        .advance     (advance),
        .fb_full     (fb_full),
        .head        (q_slot)
    );

    for (genvar i = 0; i < fetch_pkg::LANES; i++) begin : g_lane
        predecode_lane u_lane (
            .clk     (clk),
            .rst_n   (rst_n),
            .flush   (flush),
            .advance (advance),
            .q       (q_slot[i]),
            .d       (d_slot[i])
        );
    end

    dispatch_pair u_dispatch (
        .clk           (clk),
        .rst_n         (rst_n),
        .lanes         (d_slot),
        .out_ready     (out_ready),
        .advance       (advance),
        .out_valid     (out_valid),
        .out_pc0       (out_pc0),
        .out_pc1       (out_pc1),
        .out_insn0     (out_insn0),
        .out_insn1     (out_insn1),
        .out_npc0      (out_npc0),
        .out_npc1      (out_npc1),
        .out_class0    (out_class0),
        .out_class1    (out_class1),
        .out_excp_arg0 (out_excp_arg0),
        .out_excp_arg1 (out_excp_arg1)
    );

endmodule

// ==== verilog/fetch_slot_if.sv ====
interface fetch_slot_if;

    logic                      valid;
    fetch_pkg::fetch_entry_t   entry;
    fetch_pkg::insn_class_e    cls;
    logic                      excp;    // excp_arg nonzero.

    // queue head, no class yet.
    modport src (
        output valid,
        output entry
    );

    // registered lane output.
    modport lane (
        output valid,
        output entry,
        output cls,
        output excp
    );

    modport sink (
        input valid,
        input entry,
        input cls,
        input excp
    );

endinterface

// ==== verilog/predecode_lane.sv ====
module predecode_lane (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        flush,
    input  logic        advance,
    fetch_slot_if.sink  q,
    fetch_slot_if.lane  d
);

    logic                    valid_r;
    fetch_pkg::fetch_entry_t entry_r;
    fetch_pkg::insn_class_e  cls_r;
    logic                    excp_r;

    function automatic fetch_pkg::insn_class_e classify(
        input logic [fetch_pkg::XLEN-1:0] insn
    );
        logic [fetch_pkg::OPC_W-1:0] opc;
        opc = insn[fetch_pkg::OPC_LSB +: fetch_pkg::OPC_W];
        if (opc >= fetch_pkg::OPC_BRANCH_MIN) begin
            return fetch_pkg::CLS_BRANCH;
        end else if (opc == fetch_pkg::OPC_LOAD) begin
            return fetch_pkg::CLS_LOAD;
        end else if (opc == fetch_pkg::OPC_STORE) begin
            return fetch_pkg::CLS_STORE;
        end else if (opc == fetch_pkg::OPC_SYSTEM) begin
            return fetch_pkg::CLS_SYSTEM;
        end
        return fetch_pkg::CLS_ALU;    // everything else.
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_r <= 1'b0;
        end else if (flush) begin
            valid_r <= 1'b0;
        end else if (advance) begin
            valid_r <= q.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            entry_r <= q.entry;
            cls_r   <= classify(q.entry.insn);
            excp_r  <= |q.entry.excp_arg;
        end
    end

    assign d.valid = valid_r;
    assign d.entry = entry_r;
    assign d.cls   = cls_r;
    assign d.excp  = excp_r;

    // stalled slot must be presented unchanged to dispatch.
    a_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        (!advance && valid_r) |=> $stable(entry_r)
    );

endmodule
